/* list.f */
+incdir+verif
verilog/pin_ctrl_pkg.sv
verilog/time_base.sv
verilog/pin_channel.sv
verilog/sample_collector.sv
verilog/pin_ctrl_top.sv
verif/pin_ctrl_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= pin_ctrl_tb
RTL_TOP    ?= pin_ctrl_top
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall
PASS_TEXT  ?= Regression passed

RTL_SRCS := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/pin_ctrl_tasks.svh */
`ifndef PIN_CTRL_TASKS_SVH
`define PIN_CTRL_TASKS_SVH

// full bus address from a page number and a register offset
function automatic logic [ADDR_W-1:0] reg_addr(input int page, input logic [7:0] offset);
  return {8'(page), offset};
endfunction

task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
  @(negedge clk);
  addr    = a;
  data_in = d;
  data_wr = 1'b1;  // taken at the next rising edge
  @(negedge clk);
  data_wr = 1'b0;
endtask

task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [RD_W-1:0] d);
  @(negedge clk);
  addr    = a;
  data_rd = 1'b1;
  @(negedge clk);
  data_rd = 1'b0;
  d       = data_out;  // registered at the edge that took the strobe
endtask

task automatic sample_read(input logic [SEL_W-1:0] sel, output logic [DATA_W-1:0] word,
                           output logic valid);
  @(negedge clk);
  channel_select = sel;
  output_sample  = 1'b1;
  @(negedge clk);
  output_sample  = 1'b0;
  word           = sample_data;
  valid          = sample_valid;
endtask

// read strobe and sample strobe on the same edge, so both see one sample_cnt
task automatic read_and_sample(input logic [ADDR_W-1:0] a, input logic [SEL_W-1:0] sel,
                               output logic [RD_W-1:0] rd, output logic [DATA_W-1:0] word,
                               output logic valid);
  @(negedge clk);
  addr           = a;
  data_rd        = 1'b1;
  channel_select = sel;
  output_sample  = 1'b1;
  @(negedge clk);
  data_rd        = 1'b0;
  output_sample  = 1'b0;
  rd             = data_out;
  word           = sample_data;
  valid          = sample_valid;
endtask

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
  assert (actual === expected) else begin
    $display("Fail %s %s: expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
    errors++;
  end
endtask

task automatic check_range(input string what, input logic [31:0] low, input logic [31:0] high,
                           input logic [31:0] actual);
  assert ((actual >= low) && (actual <= high)) else begin
    $display("Fail %s %s: expected %0d to %0d actual %0d", test_name, what, low, high, actual);
    errors++;
  end
endtask

task automatic report_problem(input string msg);
  $display("%s: %s", test_name, msg);  // plain words, no value pair to show
  errors++;
endtask

task automatic begin_test(input string name);
  test_name       = name;
  errors_at_start = errors;
endtask

task automatic end_test();
  if (errors == errors_at_start) begin
    tests_passed++;
    $display("test %s: ok", test_name);
  end else begin
    tests_failed++;
    $display("test %s: %0d errors", test_name, errors - errors_at_start);
  end
endtask

`endif

/* verif/pin_ctrl_tb.sv */
`timescale 1ns/1ps

module pin_ctrl_tb;
  import pin_ctrl_pkg::*;

  localparam int NUM_PINS   = 4;
  localparam int HALF_CYCLE = 20;  // 40 ns clock
  localparam int SQUARE_CH  = 1;
  localparam int CONST_CH   = 2;
  localparam int STREAM_CH  = 3;
  localparam int TIME_GAP   = 6;   // cycles between the two time strobes
  // cycle budget per test, the watchdog is derived from their sum
  localparam int TEST_CYCLES = 40 + 90 + 60 + 70 + 20 + 20;
  localparam int WATCHDOG_CYCLES = 6 * TEST_CYCLES + 200;

  logic                clk;
  logic                reset;
  logic [ADDR_W-1:0]   addr;
  logic [DATA_W-1:0]   data_in;
  logic                data_wr;
  logic                data_rd;
  logic [RD_W-1:0]     data_out;
  logic                output_sample;
  logic [SEL_W-1:0]    channel_select;
  logic [DATA_W-1:0]   sample_data;
  logic                sample_valid;
  logic [NUM_PINS-1:0] pin_in;
  logic [NUM_PINS-1:0] pin_out;
  logic [NUM_PINS-1:0] pin_oe;

  int     errors;
  int     errors_at_start;
  int     tests_passed;
  int     tests_failed;
  string  test_name;
  integer seed;
  logic   const_window;  // set while channel 2 owns the only active pin
  logic   rd_seen;       // data_rd as taken at the last rising edge

  `include "pin_ctrl_tasks.svh"

  pin_ctrl_top #(
    .NUM_PINS (NUM_PINS)
  ) DUT (
    .clk            (clk),
    .reset          (reset),
    .addr           (addr),
    .data_in        (data_in),
    .data_wr        (data_wr),
    .data_rd        (data_rd),
    .data_out       (data_out),
    .output_sample  (output_sample),
    .channel_select (channel_select),
    .sample_data    (sample_data),
    .sample_valid   (sample_valid),
    .pin_in         (pin_in),
    .pin_out        (pin_out),
    .pin_oe         (pin_oe)
  );

  always #HALF_CYCLE clk = ~clk;

  always_ff @(posedge clk) rd_seen <= data_rd;

  // checks run on the falling edge where every DUT output is settled
  assert property (@(negedge clk) disable iff (reset) (data_out != '0) |-> rd_seen)
    else begin
      errors++;
      $display("%s: data_out is nonzero without a read strobe", test_name);
    end

  assert property (@(negedge clk) disable iff (reset)
                   !pin_oe[2] && !pin_oe[3] && !(const_window && pin_oe[0]))
    else begin
      errors++;
      $display("%s: a channel drives its pin when it should not", test_name);
    end

  // nco at 2^30 per cycle gives a period of four cycles with two high and two low
  assert property (@(negedge clk) disable iff (reset)
                   (pin_oe[0] && $past(pin_oe[0], 4)) |->
                   ((pin_out[0] == $past(pin_out[0], 4)) && (pin_out[0] != $past(pin_out[0], 2))))
    else begin
      errors++;
      $display("%s: square wave on pin 0 lost its 4 cycle period", test_name);
    end

  task automatic wait_pin_oe(input int pin, input logic level, input int limit, output bit seen);
    int count;
    count = 0;
    while ((pin_oe[pin] !== level) && (count < limit)) begin
      @(negedge clk);
      count++;
    end
    seen = (pin_oe[pin] === level);
    if (!seen) begin
      report_problem($sformatf("pin_oe[%0d] did not go to %0b within %0d cycles", pin, level, limit));
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run went past %0d cycles during %s", WATCHDOG_CYCLES, test_name);
    $display("Regression failed");
    $finish;
  end

  initial begin
    logic [RD_W-1:0]   rd;
    logic [RD_W-1:0]   t0;
    logic [RD_W-1:0]   t1;
    logic [RD_W-1:0]   end_t;
    logic [DATA_W-1:0] word;
    logic              valid;
    logic              level;
    logic              last_out;
    bit                seen;
    int                edges;
    int                waited;
    clk             = 1'b0;
    reset           = 1'b1;
    addr            = '0;
    data_in         = '0;
    data_wr         = 1'b0;
    data_rd         = 1'b0;
    output_sample   = 1'b0;
    channel_select  = '0;
    pin_in          = '0;
    seed            = 15805;
    errors          = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    test_name       = "reset";
    const_window    = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    begin_test("status_and_time");
    for (int p = 1; p <= NUM_PINS; p++) begin
      bus_read(reg_addr(p, ADDR_STATUS_REG), rd);
      check_value($sformatf("status page %0d", p), p, rd);  // status word is the page number
    end
    bus_write(reg_addr(0, ADDR_GLOBAL_CMD), GCMD_START);
    bus_read(reg_addr(0, ADDR_TIME_LOW), t0);
    repeat (TIME_GAP - 2) @(negedge clk);  // a read occupies two falling edges
    bus_read(reg_addr(0, ADDR_TIME_LOW), t1);
    check_value("time step", TIME_GAP, 32'(RD_W'(t1 - t0)));
    end_test();

    begin_test("constant_drive");
    bus_read(reg_addr(0, ADDR_TIME_LOW), t0);
    end_t = t0 + 16'd30;
    bus_write(reg_addr(CONST_CH, ADDR_END_TIME), 32'(end_t));
    const_window = 1'b1;
    bus_write(reg_addr(CONST_CH, ADDR_LOCAL_CMD), CMD_CONST);
    wait_pin_oe(CONST_CH - 1, 1'b1, 10, seen);
    if (seen) begin
      check_value("pin_out while driven", 1, pin_out[CONST_CH-1]);
    end
    wait_pin_oe(CONST_CH - 1, 1'b0, 60, seen);
    check_value("pin_out after end", 0, pin_out[CONST_CH-1]);
    bus_read(reg_addr(0, ADDR_TIME_LOW), t1);
    check_range("time after release", end_t, end_t + 16'd3, t1);
    const_window = 1'b0;
    end_test();

    begin_test("square_wave");
    bus_write(reg_addr(SQUARE_CH, ADDR_NCO_COUNTER), 32'h4000_0000);
    bus_write(reg_addr(SQUARE_CH, ADDR_LOCAL_CMD), CMD_SQUARE_WAVE);
    wait_pin_oe(SQUARE_CH - 1, 1'b1, 10, seen);
    last_out = pin_out[SQUARE_CH-1];
    edges    = 0;
    repeat (24) begin  // six full periods
      @(negedge clk);
      if (pin_out[SQUARE_CH-1] != last_out) edges++;
      last_out = pin_out[SQUARE_CH-1];
    end
    check_value("pin_out toggles", 12, edges);
    check_value("pin_oe still high", 1, pin_oe[SQUARE_CH-1]);
    end_test();

    begin_test("input_stream");
    @(negedge clk);
    pin_in = 4'($random(seed));
    level  = pin_in[STREAM_CH-1];  // held from here to the end of the run
    bus_write(reg_addr(STREAM_CH, ADDR_SAMPLE_RATE), 32'd3);
    bus_write(reg_addr(STREAM_CH, ADDR_LOCAL_CMD), CMD_INPUT_STREAM);
    repeat (40) @(negedge clk);
    bus_read(reg_addr(STREAM_CH, ADDR_SAMPLE_CNT), rd);
    check_range("sample_cnt", 12, 14, rd);  // 40 cycles at one sample per 3
    bus_read(reg_addr(STREAM_CH, ADDR_SAMPLE_REG), rd);
    check_value("sample_reg", level, rd);
    end_test();

    begin_test("sample_port");
    read_and_sample(reg_addr(STREAM_CH, ADDR_SAMPLE_CNT), SEL_W'(STREAM_CH), rd, word, valid);
    check_value("sample_valid", 1, valid);
    check_value("sample_data", {rd, 15'(STREAM_CH), level}, word);
    sample_read(8'd9, word, valid);  // no channel 9 exists
    check_value("sample_valid on bad select", 0, valid);
    end_test();

    begin_test("reset_command");
    bus_write(reg_addr(STREAM_CH, ADDR_LOCAL_CMD), CMD_RESET);
    bus_write(reg_addr(SQUARE_CH, ADDR_LOCAL_CMD), CMD_RESET);
    waited = 0;
    while ((pin_oe[SQUARE_CH-1] || pin_oe[STREAM_CH-1]) && (waited < 3)) begin
      @(negedge clk);
      waited++;
    end
    if (pin_oe[SQUARE_CH-1] || pin_oe[STREAM_CH-1]) begin
      report_problem("pin_oe still high 3 cycles after the reset commands");
    end
    bus_read(reg_addr(STREAM_CH, ADDR_SAMPLE_CNT), rd);
    check_value("sample_cnt after reset", 0, rd);
    end_test();

    $display("summary: %0d tests ok, %0d tests with errors, %0d errors",
             tests_passed, tests_failed, errors);
    if ((errors == 0) && (tests_failed == 0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verilog/pin_ctrl_top.sv */
`timescale 1ns/1ps

module pin_ctrl_top #(
  parameter int NUM_PINS = 4  // channels live on pages 1 to NUM_PINS
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [pin_ctrl_pkg::ADDR_W-1:0] addr,
  input  logic [pin_ctrl_pkg::DATA_W-1:0] data_in,
  input  logic                            data_wr,
  input  logic                            data_rd,
  output logic [pin_ctrl_pkg::RD_W-1:0]   data_out,
  input  logic                            output_sample,
  input  logic [pin_ctrl_pkg::SEL_W-1:0]  channel_select,
  output logic [pin_ctrl_pkg::DATA_W-1:0] sample_data,
  output logic                            sample_valid,
  input  logic [NUM_PINS-1:0]             pin_in,
  output logic [NUM_PINS-1:0]             pin_out,
  output logic [NUM_PINS-1:0]             pin_oe
);
  import pin_ctrl_pkg::*;

  logic [TIME_W-1:0]          current_time;      // shared by every channel
  logic [RD_W-1:0]            time_rd_data;      // page 0 readback
  logic [NUM_PINS*RD_W-1:0]   chan_rd_data;      // channel readback, channel 1 lowest
  logic [NUM_PINS*DATA_W-1:0] chan_sample_word;  // per-channel sample words

  time_base u_time_base (
    .clk          (clk),
    .reset        (reset),
    .addr         (addr),
    .data_in      (data_in),
    .data_wr      (data_wr),
    .data_rd      (data_rd),
    .current_time (current_time),
    .time_rd_data (time_rd_data)
  );

  for (genvar i = 0; i < NUM_PINS; i++) begin : g_chan
    pin_channel #(
      .POSITION (i + 1)  // page 0 is taken by the time base
    ) u_chan (
      .clk          (clk),
      .reset        (reset),
      .addr         (addr),
      .data_in      (data_in),
      .data_wr      (data_wr),
      .data_rd      (data_rd),
      .current_time (current_time),
      .pin_in       (pin_in[i]),
      .pin_out      (pin_out[i]),
      .pin_oe       (pin_oe[i]),
      .rd_data      (chan_rd_data[i*RD_W +: RD_W]),
      .sample_word  (chan_sample_word[i*DATA_W +: DATA_W])
    );
  end

  sample_collector #(
    .NUM_PINS (NUM_PINS)
  ) u_collector (
    .clk              (clk),
    .reset            (reset),
    .output_sample    (output_sample),
    .channel_select   (channel_select),
    .chan_rd_data     (chan_rd_data),
    .time_rd_data     (time_rd_data),
    .chan_sample_word (chan_sample_word),
    .data_out         (data_out),
    .sample_data      (sample_data),
    .sample_valid     (sample_valid)
  );

endmodule

/* verilog/sample_collector.sv */
`timescale 1ns/1ps

module sample_collector #(
  parameter int NUM_PINS = 4  // number of channel words to merge
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     output_sample,
  input  logic [pin_ctrl_pkg::SEL_W-1:0]           channel_select,
  input  logic [NUM_PINS*pin_ctrl_pkg::RD_W-1:0]   chan_rd_data,
  input  logic [pin_ctrl_pkg::RD_W-1:0]            time_rd_data,
  input  logic [NUM_PINS*pin_ctrl_pkg::DATA_W-1:0] chan_sample_word,
  output logic [pin_ctrl_pkg::RD_W-1:0]            data_out,
  output logic [pin_ctrl_pkg::DATA_W-1:0]          sample_data,
  output logic                                     sample_valid
);
  import pin_ctrl_pkg::*;

  logic [DATA_W-1:0] sel_word;  // sample word of the selected channel
  logic              sel_hit;   // channel_select names an existing channel

  // only the addressed block returns a nonzero word, so OR acts as the mux
  always_comb begin
    data_out = time_rd_data;
    for (int i = 0; i < NUM_PINS; i++) begin
      data_out = data_out | chan_rd_data[i*RD_W +: RD_W];
    end
  end

  // channels are numbered from 1, entry i holds channel i+1
  always_comb begin
    sel_hit  = 1'b0;
    sel_word = '0;
    for (int i = 0; i < NUM_PINS; i++) begin
      if (channel_select == SEL_W'(i + 1)) begin
        sel_hit  = 1'b1;
        sel_word = chan_sample_word[i*DATA_W +: DATA_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
      sample_data  <= '0;
    end else begin
      sample_valid <= output_sample & sel_hit;  // one-cycle pulse with the word
      sample_data  <= (output_sample && sel_hit) ? sel_word : '0;
    end
  end

  assert property (@(posedge clk) disable iff (reset) sample_valid |-> $past(output_sample))
    else $error("sample_collector: sample_valid without a strobe");

endmodule

/* verilog/pin_channel.sv */
`timescale 1ns/1ps

module pin_channel #(
  parameter int POSITION = 1  // page number, also the channel id reported back
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [pin_ctrl_pkg::ADDR_W-1:0] addr,
  input  logic [pin_ctrl_pkg::DATA_W-1:0] data_in,
  input  logic                            data_wr,
  input  logic                            data_rd,
  input  logic [pin_ctrl_pkg::TIME_W-1:0] current_time,
  input  logic                            pin_in,
  output logic                            pin_out,
  output logic                            pin_oe,
  output logic [pin_ctrl_pkg::RD_W-1:0]   rd_data,
  output logic [pin_ctrl_pkg::DATA_W-1:0] sample_word
);
  import pin_ctrl_pkg::*;

  localparam logic [7:0]  PAGE   = 8'(POSITION);   // upper address byte of this channel
  localparam logic [14:0] POS_ID = 15'(POSITION);  // id field inside the sample word

  logic [DATA_W-1:0] command;          // pending local command, cleared once accepted
  logic [DATA_W-1:0] nco_counter;      // phase increment per clock
  logic [TIME_W-1:0] end_time;         // stop time for const, square and stream
  logic [DATA_W-1:0] sample_rate;      // clocks between samples
  logic [TIME_W-1:0] rec_start_time;   // opens a recording window when nonzero
  logic [DATA_W-1:0] cnt_sample_rate;  // sampler countdown
  logic [DATA_W-1:0] nco_pa;           // phase accumulator
  logic [RD_W-1:0]   sample_cnt;       // number of samples taken
  logic              sample_register;  // last sampled pin level

  pin_state_t state;
  pin_state_t next_state;

  logic wr_hit;       // write addressed to this page
  logic rd_hit;       // read addressed to this page
  logic rec_window;   // current_time inside the recording window
  logic time_done;    // end_time set and reached
  logic clear_cmd;    // FSM consumed the command
  logic clear_rec;    // recording window closes
  logic clear_smp;    // sample state back to zero
  logic reload_cnt;   // countdown restarts from sample_rate
  logic dec_cnt;      // countdown steps
  logic take_sample;  // capture pin_in this cycle
  logic nco_one;      // const mode pins the accumulator high
  logic nco_clear;    // a state is being left

  assign wr_hit     = (addr[ADDR_W-1 -: 8] == PAGE) & data_wr;
  assign rd_hit     = (addr[ADDR_W-1 -: 8] == PAGE) & data_rd;
  assign rec_window = (rec_start_time != '0) && (rec_start_time < current_time) &&
                      (current_time <= end_time);
  assign time_done  = (end_time != '0) && (current_time >= end_time);

  always_ff @(posedge clk) begin
    if (reset) begin
      nco_counter <= '0;
      end_time    <= '0;
      sample_rate <= '0;
    end else if (wr_hit) begin
      case (addr[7:0])
        ADDR_NCO_COUNTER: nco_counter <= data_in;
        ADDR_END_TIME:    end_time    <= data_in;
        ADDR_SAMPLE_RATE: sample_rate <= data_in;
        default:          ;  // the other offsets have their own blocks or are read-only
      endcase
    end
  end

  // the clear beats a write in the same cycle, so software keeps one idle
  // cycle between two command writes to this channel
  always_ff @(posedge clk) begin
    if (reset) begin
      command <= '0;
    end else if (clear_cmd) begin
      command <= '0;
    end else if (wr_hit && (addr[7:0] == ADDR_LOCAL_CMD)) begin
      command <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rec_start_time <= '0;
    end else if (clear_rec) begin
      rec_start_time <= '0;  // one recording window per write
    end else if (wr_hit && (addr[7:0] == ADDR_REC_START_TIME)) begin
      rec_start_time <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= ST_IDLE;
      pin_oe <= 1'b0;
    end else begin
      state  <= next_state;
      pin_oe <= (next_state == ST_CONST) || (next_state == ST_SQUARE);  // stream is input only
    end
  end

  always_comb begin
    next_state  = state;
    clear_cmd   = 1'b0;
    clear_rec   = 1'b0;
    clear_smp   = 1'b0;
    reload_cnt  = 1'b0;
    dec_cnt     = 1'b0;
    take_sample = 1'b0;
    unique case (state)
      ST_IDLE: begin
        reload_cnt = 1'b1;  // countdown sits at sample_rate while idle
        if (current_time != '0) begin  // nothing starts before the time base runs
          if (rec_window) begin
            next_state = ST_STREAM;
          end else if (command == CMD_INPUT_STREAM) begin
            clear_cmd  = 1'b1;
            next_state = ST_STREAM;
          end else if (command == CMD_SQUARE_WAVE) begin
            clear_cmd  = 1'b1;
            next_state = ST_SQUARE;
          end else if (command == CMD_CONST) begin
            clear_cmd  = 1'b1;
            next_state = ST_CONST;
          end else if (command == CMD_RESET) begin
            clear_cmd = 1'b1;  // already idle, just drop it
          end
        end
      end
      ST_SQUARE: begin
        if ((command == CMD_RESET) || time_done) begin
          clear_cmd  = 1'b1;
          next_state = ST_IDLE;
        end
      end
      ST_CONST: begin
        if ((command == CMD_RESET) || (current_time >= end_time)) begin
          clear_cmd  = 1'b1;  // no zero check here, an unset end_time ends at once
          next_state = ST_IDLE;
        end
      end
      ST_STREAM: begin
        if (cnt_sample_rate <= 1) begin  // a rate of 0 behaves like 1
          take_sample = 1'b1;
          reload_cnt  = 1'b1;
        end else begin
          dec_cnt = 1'b1;
        end
        if (command == CMD_RESET) begin
          clear_cmd  = 1'b1;
          clear_rec  = 1'b1;
          clear_smp  = 1'b1;
          next_state = ST_IDLE;
        end else if (time_done) begin
          clear_rec  = 1'b1;
          clear_smp  = 1'b1;
          next_state = ST_IDLE;
        end
      end
      default: next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_sample_rate <= '0;
      sample_cnt      <= '0;
      sample_register <= 1'b0;
    end else if (clear_smp) begin
      cnt_sample_rate <= '0;
      sample_cnt      <= '0;
      sample_register <= 1'b0;
    end else begin
      if (reload_cnt) begin
        cnt_sample_rate <= sample_rate;
      end else if (dec_cnt) begin
        cnt_sample_rate <= cnt_sample_rate - 32'd1;
      end
      if (take_sample) begin
        sample_register <= pin_in;
        sample_cnt      <= sample_cnt + 16'd1;
      end
    end
  end

  // output frequency is about f_clk * nco_counter / 2^32
  assign nco_one   = (next_state == ST_CONST);  // set on entry so pin_out rises with pin_oe
  assign nco_clear = (state != ST_IDLE) && (next_state == ST_IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      nco_pa <= '0;
    end else if (nco_clear) begin
      nco_pa <= '0;
    end else if (nco_one) begin
      nco_pa <= '1;
    end else begin
      nco_pa <= nco_pa + nco_counter;
    end
  end

  assign pin_out = nco_pa[DATA_W-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data <= '0;
    end else if (rd_hit) begin
      case (addr[7:0])
        ADDR_SAMPLE_REG: rd_data <= {15'd0, sample_register};
        ADDR_SAMPLE_CNT: rd_data <= sample_cnt;
        ADDR_STATUS_REG: rd_data <= 16'(POSITION);
        default:         rd_data <= '0;
      endcase
    end else begin
      rd_data <= '0;  // zero lets the collector OR all channels together
    end
  end

  assign sample_word = {sample_cnt, POS_ID, sample_register};  // selected in the collector

  assert property (@(posedge clk) disable iff (reset) $onehot(state))
    else $error("pin_channel %0d: state is not one-hot", POSITION);

  assert property (@(posedge clk) disable iff (reset) (state == ST_IDLE) |-> !pin_oe)
    else $error("pin_channel %0d: pin_oe high while idle", POSITION);

endmodule

/* verilog/time_base.sv */
`timescale 1ns/1ps

module time_base (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [pin_ctrl_pkg::ADDR_W-1:0] addr,
  input  logic [pin_ctrl_pkg::DATA_W-1:0] data_in,
  input  logic                            data_wr,
  input  logic                            data_rd,
  output logic [pin_ctrl_pkg::TIME_W-1:0] current_time,
  output logic [pin_ctrl_pkg::RD_W-1:0]   time_rd_data
);
  import pin_ctrl_pkg::*;

  logic page_hit;  // page 0 belongs to the time base
  logic cmd_wr;    // write to the global command register
  logic running;   // counter advances while set

  assign page_hit = (addr[ADDR_W-1 -: 8] == 8'd0);
  assign cmd_wr   = page_hit & data_wr & (addr[7:0] == ADDR_GLOBAL_CMD);

  always_ff @(posedge clk) begin
    if (reset) begin
      running      <= 1'b0;
      current_time <= '0;
    end else begin
      if (cmd_wr && (data_in == GCMD_CLEAR)) begin
        current_time <= '0;  // clear wins over counting in the same cycle
      end else if (running) begin
        current_time <= current_time + 1'b1;
      end
      if (cmd_wr) begin
        case (data_in)
          GCMD_START:             running <= 1'b1;
          GCMD_STOP, GCMD_CLEAR:  running <= 1'b0;  // clear also stops the count
          default:                running <= running;  // unknown codes are ignored
        endcase
      end
    end
  end

  // readback is registered so it lines up with the channel read words
  always_ff @(posedge clk) begin
    if (reset) begin
      time_rd_data <= '0;
    end else if (page_hit && data_rd && (addr[7:0] == ADDR_TIME_LOW)) begin
      time_rd_data <= current_time[RD_W-1:0];
    end else begin
      time_rd_data <= '0;  // idle word is zero so the collector can OR it in
    end
  end

endmodule

/* verilog/pin_ctrl_pkg.sv */
package pin_ctrl_pkg;

  localparam int ADDR_W = 16;  // command bus address, page byte over register byte
  localparam int DATA_W = 32;  // write data and sample word width
  localparam int RD_W   = 16;  // read bus width
  localparam int TIME_W = 32;  // width of the shared time base
  localparam int SEL_W  = 8;   // channel_select width on the sample port

  // register offsets live in the low address byte
  localparam logic [7:0] ADDR_GLOBAL_CMD     = 8'd0;
  localparam logic [7:0] ADDR_NCO_COUNTER    = 8'd1;
  localparam logic [7:0] ADDR_END_TIME       = 8'd2;
  localparam logic [7:0] ADDR_LOCAL_CMD      = 8'd3;
  localparam logic [7:0] ADDR_SAMPLE_RATE    = 8'd4;
  localparam logic [7:0] ADDR_SAMPLE_REG     = 8'd5;
  localparam logic [7:0] ADDR_REC_START_TIME = 8'd6;
  localparam logic [7:0] ADDR_SAMPLE_CNT     = 8'd7;
  localparam logic [7:0] ADDR_STATUS_REG     = 8'd8;
  localparam logic [7:0] ADDR_TIME_LOW       = 8'd9;  // page 0 only, low half of current_time

  localparam logic [DATA_W-1:0] CMD_CONST        = 32'd2;  // hold pin high until end_time
  localparam logic [DATA_W-1:0] CMD_SQUARE_WAVE  = 32'd3;  // nco output until end_time
  localparam logic [DATA_W-1:0] CMD_INPUT_STREAM = 32'd4;  // periodic input sampling
  localparam logic [DATA_W-1:0] CMD_RESET        = 32'd5;  // back to idle from any state

  localparam logic [DATA_W-1:0] GCMD_START = 32'd1;  // time base counts
  localparam logic [DATA_W-1:0] GCMD_STOP  = 32'd2;  // time base holds
  localparam logic [DATA_W-1:0] GCMD_CLEAR = 32'd3;  // time base zeroed and stopped

  typedef enum logic [3:0] {
    ST_IDLE   = 4'b0001,
    ST_CONST  = 4'b0010,
    ST_STREAM = 4'b0100,
    ST_SQUARE = 4'b1000
  } pin_state_t;  // one-hot channel mode

endpackage
